// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = tb_pc_bus
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SOURCES  = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+.
pc_bus_pkg.sv
sys_bus_if.sv
bus_cycle_gen.sv
bus_command_ctrl.sv
bus_devices.sv
pc_bus_top.sv
tb_pc_bus.sv

// File: bus_command_ctrl.sv
/* Bus command controller
   8288-style status decoder producing ALE, DEN, DT/R and the command strobes */

`timescale 1ns/100ps
`default_nettype none

module bus_command_ctrl (
   input  wire logic      clk,
   input  wire logic      rst_n,
   sys_bus_if.controller  bus
);
   import pc_bus_pkg::*;

   ctrl_state_e state;
   ctrl_state_e state_nxt;

   // Latched command kind
   logic mrdc;
   logic amwc;
   logic iorc;
   logic aiowc;
   logic inta;

   logic active;
   logic cmd_phase;
   logic rd_kind;
   logic wr_kind;

   // Halt and passive start no cycle
   assign active = (bus.status != status_passive) && (bus.status != status_halt);

   assign cmd_phase = (state == cmd_early) || (state == cmd_late);
   assign rd_kind   = mrdc | iorc | inta;  // Data flows toward the CPU
   assign wr_kind   = amwc | aiowc;

   assign bus.ale = (state == idle) && active;
   assign bus.dtr = !((state != idle) && rd_kind);
   assign bus.den = ((state == cmd_late) && rd_kind) || ((state != idle) && wr_kind);

   // Commands active in both command phases
   assign bus.mrdc_n  = !(cmd_phase && mrdc);
   assign bus.amwc_n  = !(cmd_phase && amwc);
   assign bus.iorc_n  = !(cmd_phase && iorc);
   assign bus.aiowc_n = !(cmd_phase && aiowc);
   assign bus.inta_n  = !(cmd_phase && inta);

   always_comb begin
      state_nxt = state;
      case (state)
         idle:      if (active) state_nxt = cmd_early;
         cmd_early: state_nxt = cmd_late;
         cmd_late:  state_nxt = recover;
         recover:   state_nxt = idle;
         default:   state_nxt = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         state <= idle;
      else
         state <= state_nxt;
   end

   // Status sampled every idle cycle, frozen once the sequence runs
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mrdc  <= 1'b0;
         amwc  <= 1'b0;
         iorc  <= 1'b0;
         aiowc <= 1'b0;
         inta  <= 1'b0;
      end else if (state == idle) begin
         mrdc  <= (bus.status == status_mem_read) || (bus.status == status_code_fetch);
         amwc  <= (bus.status == status_mem_write);
         iorc  <= (bus.status == status_io_read);
         aiowc <= (bus.status == status_io_write);
         inta  <= (bus.status == status_inta);
      end
   end

endmodule

`default_nettype wire

// File: bus_cycle_gen.sv
/* Bus cycle generator
   Turns one Wishbone transfer into a T1..T4 bus cycle with a status code */

`timescale 1ns/100ps
`default_nettype none

module bus_cycle_gen (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire logic                     cyc,
   input  wire logic                     stb,
   input  wire logic                     we,
   input  wire pc_bus_pkg::addr_t        adr,
   input  wire pc_bus_pkg::data_t        dat_w,
   input  wire pc_bus_pkg::cycle_kind_e  kind,
   output      pc_bus_pkg::data_t        dat_r,
   output      logic                     ack,
   sys_bus_if.master                     bus
);
   import pc_bus_pkg::*;

   t_state_e    t_state;
   bus_status_e code_q;  // Status for the accepted transfer
   addr_t       addr_q;
   data_t       wdata_q;
   logic        start;

   // Map host request onto a processor status code
   function automatic bus_status_e decode_status(input cycle_kind_e k, input logic wr);
      bus_status_e s;
      case (k)
         cycle_mem:  s = wr ? status_mem_write : status_mem_read;
         cycle_io:   s = wr ? status_io_write : status_io_read;
         cycle_inta: s = status_inta; // Direction comes from the code
         default:    s = status_passive;
      endcase
      return s;
   endfunction

   assign start = cyc && stb && (t_state == t_idle);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         t_state <= t_idle;
         code_q  <= status_passive;
      end else begin
         case (t_state)
            t_idle: begin
               if (start) begin
                  t_state <= t1;
                  code_q  <= decode_status(kind, we);
               end
            end
            t1:      t_state <= t2;
            t2:      t_state <= t3;
            t3:      t_state <= t4;
            t4:      t_state <= t_done;
            t_done:  t_state <= t_idle;
            default: t_state <= t_idle;
         endcase
      end
   end

   // Address and write data held from T1 through T4
   always_ff @(posedge clk) begin
      if (start) begin
         addr_q  <= adr;
         wdata_q <= dat_w;
      end
   end

   // End of T3 lines up with the end of the late command phase
   always_ff @(posedge clk) begin
      if (t_state == t3)
         dat_r <= bus.rdata;
   end

   // Status is only driven during T1
   assign bus.status = (t_state == t1) ? code_q : status_passive;
   assign bus.addr   = addr_q;
   assign bus.wdata  = wdata_q;

   assign ack = (t_state == t_done);

endmodule

`default_nettype wire

// File: bus_devices.sv
/* Bus devices
   Address latch, RAM, I/O registers and interrupt vector on the local bus */

`timescale 1ns/100ps
`default_nettype none

`include "pc_bus_config.svh"

module bus_devices (
   input  wire logic  clk,
   input  wire logic  rst_n,
   sys_bus_if.device  bus
);
   import pc_bus_pkg::*;

   localparam int ram_aw = $clog2(`PC_MEM_DEPTH);
   localparam int io_aw  = $clog2(`PC_IO_PORTS);
   localparam addr_t vec_port = addr_t'(`PC_IO_PORTS - 1); // Also feeds the vector

   addr_t addr_q;
   data_t ram [`PC_MEM_DEPTH];
   data_t io_regs [`PC_IO_PORTS];
   data_t vector;

   logic mwr_q;  // Write strobes seen on the previous edge
   logic iowr_q;
   logic mem_hit;
   logic io_hit;
   logic mem_wr;
   logic io_wr;
   logic [ram_aw-1:0] ram_idx;
   logic [io_aw-1:0]  io_idx;

   // Transparent while ALE is high, like a '373
   always_ff @(posedge clk) begin
      if (bus.ale)
         addr_q <= bus.addr;
   end

   assign mem_hit = addr_q < addr_t'(`PC_MEM_DEPTH);
   assign io_hit  = addr_q < addr_t'(`PC_IO_PORTS);
   assign ram_idx = addr_q[ram_aw-1:0];
   assign io_idx  = addr_q[io_aw-1:0];

   // Commit on the second strobe cycle, the edge ending the late phase
   assign mem_wr = !bus.amwc_n && mwr_q && bus.dtr;
   assign io_wr  = !bus.aiowc_n && iowr_q && bus.dtr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mwr_q  <= 1'b0;
         iowr_q <= 1'b0;
      end else begin
         mwr_q  <= !bus.amwc_n;
         iowr_q <= !bus.aiowc_n;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_wr && mem_hit)
         ram[ram_idx] <= bus.wdata;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         io_regs <= '{default: '0};
         vector  <= '0;
      end else if (io_wr && io_hit) begin
         io_regs[io_idx] <= bus.wdata;
         if (addr_q == vec_port)
            vector <= bus.wdata;
      end
   end

   // Read data only while the transceiver faces the CPU
   always_comb begin
      bus.rdata = `PC_UNMAPPED;
      if (bus.den && !bus.dtr) begin
         if (!bus.mrdc_n) begin
            if (mem_hit) bus.rdata = ram[ram_idx];
         end else if (!bus.iorc_n) begin
            if (io_hit) bus.rdata = io_regs[io_idx];
         end else if (!bus.inta_n) begin
            bus.rdata = vector;
         end
      end
   end

endmodule

`default_nettype wire

// File: pc_bus_config.svh
/* PC local bus configuration
   Bus widths, device sizes and the value returned for unmapped reads */

`ifndef PC_BUS_CONFIG_SVH
`define PC_BUS_CONFIG_SVH

// Address and data widths of the local bus
`define PC_ADDR_W    20
`define PC_DATA_W    8

// Device sizes
`define PC_MEM_DEPTH 256 // RAM bytes from address zero
`define PC_IO_PORTS  4   // I/O registers from port zero

// Read value when no device answers
`define PC_UNMAPPED  8'hff

`endif

// File: pc_bus_pkg.sv
/* PC bus package
   Address and data types, status codes and FSM encodings */

`default_nettype none

`include "pc_bus_config.svh"

package pc_bus_pkg;

   typedef logic [`PC_ADDR_W-1:0] addr_t;
   typedef logic [`PC_DATA_W-1:0] data_t;

   // Processor status lines S2..S0, active low
   typedef enum logic [2:0] {
      status_inta       = 3'b000,
      status_io_read    = 3'b001,
      status_io_write   = 3'b010,
      status_halt       = 3'b011,
      status_code_fetch = 3'b100,
      status_mem_read   = 3'b101,
      status_mem_write  = 3'b110,
      status_passive    = 3'b111
   } bus_status_e;

   // Kind of host transfer
   typedef enum logic [1:0] {cycle_mem, cycle_io, cycle_inta} cycle_kind_e;

   // Command controller sequence
   typedef enum logic [1:0] {idle, cmd_early, cmd_late, recover} ctrl_state_e;

   // Bus cycle T-states
   typedef enum logic [2:0] {t_idle, t1, t2, t3, t4, t_done} t_state_e;

endpackage

`default_nettype wire

// File: pc_bus_top.sv
/* PC local bus top level
   Wishbone host port into cycle generator, command controller and devices */

`timescale 1ns/100ps
`default_nettype none

module pc_bus_top (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire logic                     cyc,
   input  wire logic                     stb,
   input  wire logic                     we,
   input  wire pc_bus_pkg::addr_t        adr,
   input  wire pc_bus_pkg::data_t        dat_w,
   input  wire pc_bus_pkg::cycle_kind_e  kind,
   output      pc_bus_pkg::data_t        dat_r,
   output      logic                     ack
);

   sys_bus_if bus_i ();

   // CPU side of the bus
   bus_cycle_gen u_cycle_gen (
      .clk   (clk),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .kind  (kind),
      .dat_r (dat_r),
      .ack   (ack),
      .bus   (bus_i.master)
   );

   bus_command_ctrl u_cmd_ctrl (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus_i.controller)
   );

   // Memory, ports and vector
   bus_devices u_devices (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus_i.device)
   );

endmodule

`default_nettype wire

// File: sys_bus_if.sv
/* Local system bus
   Status, address and data from the CPU side, commands from the controller */

`timescale 1ns/100ps
`default_nettype none

interface sys_bus_if;
   import pc_bus_pkg::*;

   bus_status_e status; // S2..S0 from the cycle generator
   addr_t       addr;
   data_t       wdata;
   data_t       rdata;   // Read data from the devices

   logic ale;
   logic den;
   logic dtr;           // High for transmit, low for receive
   logic mrdc_n;
   logic amwc_n;
   logic iorc_n;
   logic aiowc_n;
   logic inta_n;

   modport master (
      output status, addr, wdata,
      input  rdata
   );

   modport controller (
      input  status,
      output ale, den, dtr, mrdc_n, amwc_n, iorc_n, aiowc_n, inta_n
   );

   modport device (
      input  ale, den, dtr, addr, wdata,
      input  mrdc_n, amwc_n, iorc_n, aiowc_n, inta_n,
      output rdata
   );

endinterface

`default_nettype wire

// File: tb_pc_bus.sv
/* PC local bus testbench
   Directed Wishbone transfers against a reference model of RAM, ports and vector */

`timescale 1ns/100ps
`default_nettype none

`include "pc_bus_config.svh"

module tb_pc_bus;
   import pc_bus_pkg::*;

   localparam int ack_edges  = 5;    // Rising edges from acceptance until ack is seen
   localparam int max_cycles = 2000; // About 60 transfers of 7 cycles, with margin

   logic        clk;
   logic        rst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   addr_t       adr;
   data_t       dat_w;
   cycle_kind_e kind;
   data_t       dat_r;
   logic        ack;

   data_t ref_ram [`PC_MEM_DEPTH];
   data_t ref_io [`PC_IO_PORTS];
   data_t ref_vec;
   addr_t used_addr [12];

   logic [31:0] rng_state = 32'hbac47366;
   int errors = 0;
   int checks = 0;
   int cycle_count = 0;
   int ack_count = 0;

   pc_bus_top DUT (
      .clk   (clk),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .kind  (kind),
      .dat_r (dat_r),
      .ack   (ack)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (ack)
         ack_count <= ack_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("Error: run stopped after %0d cycles without finishing", cycle_count);
         $display("test failed");
         $finish;
      end
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      ref_io  = '{default: '0};
      ref_vec = '0;
   endtask

   // One Wishbone transfer; hold keeps stb up for a back-to-back request
   task automatic transfer(input cycle_kind_e k, input logic wr, input addr_t a,
                           input data_t wd, input bit hold, output data_t rd);
      int edges;
      @(negedge clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = wr;
      kind  = k;
      adr   = a;
      dat_w = wd;
      edges = 0;
      do begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end while (!ack && edges < 20);
      rd = dat_r;
      checks++;
      if (!ack) begin
         errors++;
         $display("Error at %0t ns: no ack within %0d cycles", $time, edges);
      end else if (edges != ack_edges) begin
         report_value("ack latency", edges, ack_edges);
      end
      @(posedge clk); // Host samples ack here
      if (!hold) begin
         @(negedge clk);
         cyc = 1'b0;
         stb = 1'b0;
      end
   endtask

   task automatic write_cycle(input cycle_kind_e k, input addr_t a, input data_t d,
                              input bit hold);
      data_t ignored;
      transfer(k, 1'b1, a, d, hold, ignored);
      if (k == cycle_mem && a < addr_t'(`PC_MEM_DEPTH)) begin
         ref_ram[int'(a)] = d;
      end else if (k == cycle_io && a < addr_t'(`PC_IO_PORTS)) begin
         ref_io[int'(a)] = d;
         if (a == addr_t'(`PC_IO_PORTS - 1))
            ref_vec = d; // Top port also loads the vector
      end
   endtask

   task automatic read_check(input cycle_kind_e k, input addr_t a, input bit hold);
      data_t got;
      data_t exp;
      exp = `PC_UNMAPPED;
      if (k == cycle_inta)
         exp = ref_vec;
      else if (k == cycle_mem && a < addr_t'(`PC_MEM_DEPTH))
         exp = ref_ram[int'(a)];
      else if (k == cycle_io && a < addr_t'(`PC_IO_PORTS))
         exp = ref_io[int'(a)];
      transfer(k, 1'b0, a, 8'h00, hold, got);
      checks++;
      if (got !== exp)
         report_value($sformatf("dat_r (addr %h)", a), got, exp);
   endtask

   task automatic idle_after_reset();
      repeat (10) begin
         @(negedge clk);
         checks++;
         if (ack !== 1'b0)
            report_value("ack", ack, 0);
      end
   endtask

   task automatic memory_round_trip();
      foreach (used_addr[i]) begin
         used_addr[i] = addr_t'(next_random() & 32'hff);
         write_cycle(cycle_mem, used_addr[i], data_t'(next_random()), 1'b0);
      end
      foreach (used_addr[i])
         read_check(cycle_mem, used_addr[i], 1'b0);
   endtask

   // High writes must not alias onto the low RAM bytes
   task automatic memory_unmapped();
      logic [31:0] r;
      addr_t lo;
      addr_t hi;
      repeat (3) begin
         r  = next_random();
         lo = addr_t'(r & 32'hff);
         hi = {r[19:8] | 12'h001, r[7:0]};
         write_cycle(cycle_mem, lo, data_t'(next_random()), 1'b0);
         write_cycle(cycle_mem, hi, data_t'(next_random()), 1'b0);
         read_check(cycle_mem, hi, 1'b0);
         read_check(cycle_mem, lo, 1'b0);
      end
   endtask

   task automatic io_ports();
      for (int p = 0; p < `PC_IO_PORTS; p++)
         write_cycle(cycle_io, addr_t'(p), data_t'(next_random()), 1'b0);
      for (int p = 0; p < `PC_IO_PORTS; p++)
         read_check(cycle_io, addr_t'(p), 1'b0);
      write_cycle(cycle_io, 20'h00004, data_t'(next_random()), 1'b0);
      read_check(cycle_io, 20'h00000, 1'b0);
      read_check(cycle_io, 20'h00004, 1'b0);
      read_check(cycle_io, 20'h00007, 1'b0);
      read_check(cycle_io, 20'h003f0, 1'b0);
   endtask

   task automatic interrupt_ack();
      apply_reset();
      read_check(cycle_inta, 20'h00000, 1'b0); // Vector cleared by reset
      write_cycle(cycle_io, 20'h00003, data_t'(next_random()), 1'b0);
      read_check(cycle_inta, 20'h00000, 1'b0);
      write_cycle(cycle_io, 20'h00003, data_t'(next_random()), 1'b0);
      write_cycle(cycle_io, 20'h00002, data_t'(next_random()), 1'b0); // Must leave vector alone
      read_check(cycle_inta, 20'h00000, 1'b0);
   endtask

   task automatic back_to_back();
      int acks_before;
      addr_t a;
      acks_before = ack_count;
      for (int i = 0; i < 4; i++) begin
         a = addr_t'(next_random() & 32'hff);
         write_cycle(cycle_mem, a, data_t'(next_random()), 1'b1);
         read_check(cycle_mem, a, i != 3);
      end
      checks++;
      if (ack_count - acks_before != 8)
         report_value("ack count", ack_count - acks_before, 8);
   endtask

   initial begin
      rst_n = 1'b0;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      dat_w = '0;
      kind  = cycle_mem;
      apply_reset();
      idle_after_reset();
      memory_round_trip();
      memory_unmapped();
      io_ports();
      interrupt_ack();
      back_to_back();
      repeat (2) @(negedge clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire
